//--- common/scope_pkg.sv
// Sizes, register map and capture states shared by the capture engine and its testbench
package scope_pkg;

    localparam int n_channels     = 4;
    localparam int chan_width     = $clog2(n_channels);
    localparam int sample_width   = 16;
    // Channel tag in the upper half, sample in the lower half
    localparam int word_width     = 32;
    localparam int n_triggers     = 8;
    localparam int trig_sel_width = $clog2(n_triggers);
    localparam int reg_addr_width = 3;
    localparam int fifo_depth     = 16;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    // Frame length, pre-trigger position and word counter all share this width
    localparam int count_width    = 16;

    typedef enum logic [reg_addr_width-1:0] {
        reg_period   = 3'd0,
        reg_enable   = 3'd1,
        reg_trig_sel = 3'd2,
        reg_ack      = 3'd3,
        reg_trig_pos = 3'd4,
        reg_status   = 3'd5
    } reg_addr_e;

    typedef enum logic [1:0] {
        cap_idle    = 2'd0,
        cap_armed   = 2'd1,
        cap_filling = 2'd2,
        cap_held    = 2'd3
    } capture_state_e;

endpackage

//--- scope/scope_control.sv
// Settings registers behind the four-phase req/ack register port, also issuing trigger and ack pulses
`timescale 1ns/1ns

module scope_control import scope_pkg::*; (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      reg_req,
    input  logic                      reg_write,
    input  reg_addr_e                 reg_addr,
    input  logic [31:0]               reg_wdata,
    output logic                      reg_ack,
    output logic [31:0]               reg_rdata,
    input  capture_state_e            state,
    output logic [count_width-1:0]    period,
    output logic                      enable,
    output logic [trig_sel_width-1:0] trig_sel,
    output logic [count_width-1:0]    trig_pos,
    output logic                      soft_trigger,
    output logic                      ack_pulse
);

    logic        req_start;
    logic [31:0] read_value;

    // A request counts once, on the first edge it is seen while ack is still low
    assign req_start = reg_req && !reg_ack;

    always_comb begin
        case (reg_addr)
            reg_period:   read_value = 32'(period);
            reg_enable:   read_value = 32'(enable);
            reg_trig_sel: read_value = 32'(trig_sel);
            reg_trig_pos: read_value = 32'(trig_pos);
            reg_status:   read_value = 32'(state);
            // The write-only ack register and unknown addresses read as zero
            default:      read_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            reg_ack <= 1'b0;
        end else if (req_start) begin
            reg_ack <= 1'b1;
        end else if (!reg_req) begin
            reg_ack <= 1'b0;
        end
    end

    // Read data is captured with the ack and held until the next access
    always_ff @(posedge clock) begin
        if (req_start) begin
            reg_rdata <= read_value;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            period       <= count_width'(1);
            enable       <= 1'b0;
            trig_sel     <= '0;
            trig_pos     <= '0;
            soft_trigger <= 1'b0;
            ack_pulse    <= 1'b0;
        end else begin
            soft_trigger <= req_start && reg_write && (reg_addr == reg_trig_sel);
            ack_pulse    <= req_start && reg_write && reg_wdata[0] &&
                            (reg_addr == scope_pkg::reg_ack);
            if (req_start && reg_write) begin
                case (reg_addr)
                    reg_period:   period   <= reg_wdata[count_width-1:0];
                    reg_enable:   enable   <= reg_wdata[0];
                    reg_trig_sel: trig_sel <= reg_wdata[trig_sel_width-1:0];
                    reg_trig_pos: trig_pos <= reg_wdata[count_width-1:0];
                    default:      ;
                endcase
            end
        end
    end

endmodule

//--- scope/channel_combiner.sv
// Round-robin merge of the sample channels into one registered stream of channel-tagged words
`timescale 1ns/1ns

module channel_combiner import scope_pkg::*; (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic [n_channels-1:0]                   ch_valid,
    input  logic [n_channels-1:0][sample_width-1:0] ch_data,
    output logic [n_channels-1:0]                   ch_ready,
    output logic                                    comb_valid,
    output logic [word_width-1:0]                   comb_data,
    input  logic                                    comb_ready
);

    logic                  slot_free;
    logic                  grant_valid;
    logic [chan_width-1:0] grant;
    logic [chan_width-1:0] last_served;

    // The output register can take a word when empty or when it drains this cycle
    assign slot_free = !comb_valid || comb_ready;

    // Search starts at the channel after the last one served and wraps around
    always_comb begin
        logic [chan_width-1:0] candidate;
        grant_valid = 1'b0;
        grant       = last_served;
        for (int k = 1; k <= n_channels; k++) begin
            candidate = last_served + chan_width'(k);
            if (!grant_valid && ch_valid[candidate]) begin
                grant_valid = 1'b1;
                grant       = candidate;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < n_channels; i++) begin
            ch_ready[i] = slot_free && grant_valid && (grant == chan_width'(i));
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            comb_valid  <= 1'b0;
            last_served <= chan_width'(n_channels - 1);
        end else if (slot_free) begin
            comb_valid <= grant_valid;
            if (grant_valid) begin
                last_served <= grant;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (slot_free && grant_valid) begin
            comb_data <= {{(word_width - sample_width - chan_width){1'b0}}, grant, ch_data[grant]};
        end
    end

endmodule

//--- scope/trigger_hub.sv
// Capture FSM: qualifies triggers by the pre-trigger count, pulses the selected line, freezes until ack
`timescale 1ns/1ns

module trigger_hub import scope_pkg::*; (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic [trig_sel_width-1:0] trig_sel,
    input  logic [count_width-1:0]    trig_pos,
    input  logic                      soft_trigger,
    input  logic                      ext_trigger,
    input  logic                      ack_pulse,
    input  logic [count_width-1:0]    word_count,
    input  logic                      frame_end,
    output logic                      capture_inhibit,
    output capture_state_e            state,
    output logic [n_triggers-1:0]     trigger_out
);

    logic trig_pending;
    logic trig_request;
    logic trig_accept;

    // A trigger seen too early is held until enough pre-trigger words are in the frame
    assign trig_request = soft_trigger || ext_trigger || trig_pending;
    assign trig_accept  = (state == cap_armed) && trig_request && (word_count >= trig_pos);

    // Samples flow only while armed or filling
    assign capture_inhibit = (state == cap_idle) || (state == cap_held);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= cap_idle;
            trig_pending <= 1'b0;
            trigger_out  <= '0;
        end else begin
            trigger_out  <= '0;
            trig_pending <= (state == cap_armed) && trig_request && !trig_accept;
            if (!enable) begin
                state <= cap_idle;
            end else begin
                case (state)
                    cap_idle: begin
                        state <= cap_armed;
                    end
                    cap_armed: begin
                        if (trig_accept) begin
                            trigger_out[trig_sel] <= 1'b1;
                            state                 <= cap_filling;
                        end
                    end
                    cap_filling: begin
                        if (frame_end) begin
                            state <= cap_held;
                        end
                    end
                    cap_held: begin
                        if (ack_pulse) begin
                            state <= cap_armed;
                        end
                    end
                    default: state <= cap_idle;
                endcase
            end
        end
    end

endmodule

//--- scope/frame_packer.sv
// Gates the merged stream by the capture inhibit and cuts it into frames of the programmed length
`timescale 1ns/1ns

module frame_packer import scope_pkg::*; (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [count_width-1:0] period,
    input  logic                   capture_inhibit,
    input  logic                   comb_valid,
    input  logic [word_width-1:0]  comb_data,
    output logic                   comb_ready,
    output logic                   pk_valid,
    output logic [word_width-1:0]  pk_data,
    output logic                   pk_last,
    input  logic                   pk_ready,
    output logic [count_width-1:0] word_count,
    output logic                   frame_end
);

    logic [count_width-1:0] eff_period;
    logic [count_width:0]   next_count;
    logic                   accept;

    // A zero period would never close a frame, so it behaves as one
    assign eff_period = (period == '0) ? count_width'(1) : period;
    assign next_count = {1'b0, word_count} + 1'b1;

    // While inhibited the upstream sees no ready and stalls
    assign pk_valid   = comb_valid && !capture_inhibit;
    assign pk_data    = comb_data;
    assign comb_ready = pk_ready && !capture_inhibit;

    // Greater-or-equal also closes a frame that overran after a shorter period was written
    assign pk_last   = pk_valid && (next_count >= {1'b0, eff_period});
    assign accept    = pk_valid && pk_ready;
    assign frame_end = accept && pk_last;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            word_count <= '0;
        end else if (accept) begin
            word_count <= pk_last ? '0 : next_count[count_width-1:0];
        end
    end

endmodule

//--- scope/sample_fifo.sv
// Output FIFO for framed words, keeping each word with its last flag, valid/ready on both sides
`timescale 1ns/1ns

module sample_fifo import scope_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  pk_valid,
    input  logic [word_width-1:0] pk_data,
    input  logic                  pk_last,
    output logic                  pk_ready,
    output logic                  out_valid,
    output logic [word_width-1:0] out_data,
    output logic                  out_last,
    input  logic                  out_ready
);

    logic [word_width-1:0]     mem_data [fifo_depth];
    logic                      mem_last [fifo_depth];
    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_ptr_width:0]   count;
    logic                      wr_en;
    logic                      rd_en;

    // When full a write is still taken if a read frees a slot on the same edge
    assign pk_ready  = (count != (fifo_ptr_width + 1)'(fifo_depth)) || out_ready;
    assign out_valid = (count != '0);
    assign out_data  = mem_data[rd_ptr];
    assign out_last  = mem_last[rd_ptr];

    assign wr_en = pk_valid && pk_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= pk_data;
            mem_last[wr_ptr] <= pk_last;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- verilog/scope_top.sv
// Top level of the capture engine, connecting register file, combiner, framer, trigger FSM and FIFO
`timescale 1ns/1ns

module scope_top import scope_pkg::*; (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    reg_req,
    input  logic                                    reg_write,
    input  reg_addr_e                               reg_addr,
    input  logic [31:0]                             reg_wdata,
    output logic                                    reg_ack,
    output logic [31:0]                             reg_rdata,
    input  logic [n_channels-1:0]                   ch_valid,
    input  logic [n_channels-1:0][sample_width-1:0] ch_data,
    output logic [n_channels-1:0]                   ch_ready,
    output logic                                    out_valid,
    output logic [word_width-1:0]                   out_data,
    output logic                                    out_last,
    input  logic                                    out_ready,
    input  logic                                    ext_trigger,
    output logic [n_triggers-1:0]                   trigger_out,
    output capture_state_e                          state
);

    logic [count_width-1:0]    period;
    logic                      enable;
    logic [trig_sel_width-1:0] trig_sel;
    logic [count_width-1:0]    trig_pos;
    logic                      soft_trigger;
    logic                      ack_pulse;
    logic                      comb_valid;
    logic [word_width-1:0]     comb_data;
    logic                      comb_ready;
    logic                      pk_valid;
    logic [word_width-1:0]     pk_data;
    logic                      pk_last;
    logic                      pk_ready;
    logic [count_width-1:0]    word_count;
    logic                      frame_end;
    logic                      capture_inhibit;

    scope_control control_i (
        .clock, .rst_n, .reg_req, .reg_write, .reg_addr, .reg_wdata, .reg_ack, .reg_rdata,
        .state, .period, .enable, .trig_sel, .trig_pos, .soft_trigger, .ack_pulse
    );

    channel_combiner combiner_i (
        .clock, .rst_n, .ch_valid, .ch_data, .ch_ready, .comb_valid, .comb_data, .comb_ready
    );

    trigger_hub hub_i (
        .clock, .rst_n, .enable, .trig_sel, .trig_pos, .soft_trigger, .ext_trigger,
        .ack_pulse, .word_count, .frame_end, .capture_inhibit, .state, .trigger_out
    );

    frame_packer packer_i (
        .clock, .rst_n, .period, .capture_inhibit, .comb_valid, .comb_data, .comb_ready,
        .pk_valid, .pk_data, .pk_last, .pk_ready, .word_count, .frame_end
    );

    sample_fifo fifo_i (
        .clock, .rst_n, .pk_valid, .pk_data, .pk_last, .pk_ready,
        .out_valid, .out_data, .out_last, .out_ready
    );

endmodule

//--- bench/scope_tb.sv
// Random-stimulus testbench for the capture engine, checking data, framing, triggers and freeze
`timescale 1ns/1ns

module scope_tb import scope_pkg::*; ();

    localparam int n_test_words    = 400;
    localparam int watchdog_cycles = n_test_words * 40 + 2000;

    logic clock = 1'b0;
    logic rst_n;
    logic reg_req, reg_write, reg_ack, out_valid, out_last, out_ready, ext_trigger;
    reg_addr_e reg_addr;
    logic [31:0] reg_wdata, reg_rdata;
    logic [n_channels-1:0] ch_valid, ch_ready;
    logic [n_channels-1:0][sample_width-1:0] ch_data;
    logic [word_width-1:0] out_data;
    logic [n_triggers-1:0] trigger_out;
    capture_state_e state;

    integer seed = 32'h9d2abaa4;
    logic traffic_on = 1'b0;
    int word_errors = 0, last_errors = 0, state_errors = 0, reg_errors = 0, other_errors = 0;

    // Reference model
    logic [sample_width-1:0] chan_q [n_channels][$];
    int model_period = 1, model_trig_pos = 0, frame_count = 0;
    int out_total = 0, out_since_ack = 0, ch_since_ack = 0, pulse_count = 0;
    logic [trig_sel_width-1:0] exp_sel = '0;

    scope_top dut_i (.*);

    always #10 clock = ~clock;

    task automatic check_word(string name, logic [word_width-1:0] got, logic [word_width-1:0] exp);
        if (got !== exp) begin
            word_errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_last(string name, bit got, bit exp);
        if (got != exp) begin
            last_errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_state(string name, capture_state_e got, capture_state_e exp);
        if (got !== exp) begin
            state_errors++;
            $display("Fail at %0t ns: %s is %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_reg(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            reg_errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Four-phase access: ack is sampled at rising edges, where it holds its pre-edge value
    task automatic reg_write_task(reg_addr_e addr, logic [31:0] data);
        if (addr == reg_period) model_period = (data[15:0] == 0) ? 1 : int'(data[15:0]);
        if (addr == reg_trig_pos) model_trig_pos = int'(data[15:0]);
        if (addr == reg_trig_sel) exp_sel = data[trig_sel_width-1:0];
        @(posedge clock);
        reg_req   <= 1'b1;
        reg_write <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        do @(posedge clock); while (!reg_ack);
        reg_req <= 1'b0;
        do @(posedge clock); while (reg_ack);
    endtask

    task automatic reg_read_task(reg_addr_e addr, output logic [31:0] data);
        @(posedge clock);
        reg_req   <= 1'b1;
        reg_write <= 1'b0;
        reg_addr  <= addr;
        do @(posedge clock); while (!reg_ack);
        data = reg_rdata;
        reg_req <= 1'b0;
        do @(posedge clock); while (reg_ack);
    endtask

    task automatic read_expect(reg_addr_e addr, logic [31:0] exp, string name);
        logic [31:0] value;
        reg_read_task(addr, value);
        check_reg(name, value, exp);
    endtask

    // The status register and the state port must both show the expected capture state
    task automatic expect_status(capture_state_e exp);
        logic [31:0] value;
        reg_read_task(reg_status, value);
        check_reg("reg_status", value, 32'(exp));
        check_state("state", state, exp);
    endtask

    task automatic wait_words(int n);
        int target;
        target = out_total + n;
        while (out_total < target) @(posedge clock);
    endtask

    // Waits until the FIFO is empty, then requires the output to stay silent
    task automatic expect_quiet(int cycles);
        do @(posedge clock); while (out_valid);
        repeat (cycles) begin
            @(posedge clock);
            if (out_valid) begin
                other_errors++;
                $display("Output word appeared at %0t ns while capture was stopped", $time);
            end
        end
    endtask

    // Inputs follow valid/ready, a withheld sample stays until it is taken
    always @(posedge clock) begin
        out_ready <= ($random(seed) & 3) != 0;
        for (int i = 0; i < n_channels; i++) begin
            if (!traffic_on) begin
                ch_valid[i] <= 1'b0;
            end else if (!ch_valid[i] || ch_ready[i]) begin
                ch_valid[i] <= $random(seed) & 1;
                ch_data[i]  <= sample_width'($random(seed));
            end
        end
    end

    always @(posedge clock) begin : monitor
        int tag;
        bit exp_last;
        for (int i = 0; i < n_channels; i++) begin
            if (ch_valid[i] && ch_ready[i]) begin
                chan_q[i].push_back(ch_data[i]);
                ch_since_ack++;
            end
        end
        if (rst_n && out_valid && out_ready) begin
            tag = int'(out_data[word_width-1:sample_width]);
            if (tag >= n_channels) begin
                other_errors++;
                $display("Output word %h at %0t ns has no valid channel tag", out_data, $time);
            end else if (chan_q[tag].size() == 0) begin
                other_errors++;
                $display("Output word %h at %0t ns was never sent on its channel", out_data, $time);
            end else begin
                check_word("out_data", out_data, {16'(tag), chan_q[tag].pop_front()});
            end
            exp_last = (frame_count + 1 == model_period);
            check_last("out_last", out_last, exp_last);
            frame_count = exp_last ? 0 : frame_count + 1;
            out_total++;
            out_since_ack++;
        end
        if (rst_n && trigger_out != '0) begin
            pulse_count++;
            check_reg("trigger_out", 32'(trigger_out), 32'(1) << exp_sel);
            // The packer count can lead the channel count only by the word parked in the combiner
            if (ch_since_ack + 1 < model_trig_pos) begin
                other_errors++;
                $display("Trigger pulse at %0t ns came before enough pre-trigger words", $time);
            end
        end
    end

    initial begin
        #(watchdog_cycles * 20);
        $display("Watchdog expired: the test did not reach its end in time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0] status;
        rst_n = 1'b0;
        reg_req = 1'b0;
        reg_write = 1'b0;
        reg_addr = reg_period;
        reg_wdata = '0;
        ch_valid = '0;
        ch_data = '0;
        out_ready = 1'b0;
        ext_trigger = 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        reg_write_task(reg_period, 32'd5);
        reg_write_task(reg_trig_sel, 32'd3);
        reg_write_task(reg_trig_pos, 32'd2);
        read_expect(reg_period, 32'd5, "reg_period");
        read_expect(reg_trig_sel, 32'd3, "reg_trig_sel");
        read_expect(reg_trig_pos, 32'd2, "reg_trig_pos");
        read_expect(scope_pkg::reg_ack, 32'd0, "reg_ack");
        read_expect(reg_addr_e'(3'd6), 32'd0, "unknown address 6");
        read_expect(reg_addr_e'(3'd7), 32'd0, "unknown address 7");
        expect_status(cap_idle);
        reg_write_task(reg_enable, 32'd1);
        read_expect(reg_enable, 32'd1, "reg_enable");

        // Free-running frames without any trigger
        traffic_on <= 1'b1;
        wait_words(n_test_words / 2);
        expect_status(cap_armed);

        // Software trigger, then freeze at the end of the frame
        pulse_count = 0;
        reg_write_task(reg_trig_sel, 32'd5);
        reg_read_task(reg_status, status);
        if (status != 32'(cap_filling)) begin
            check_state("reg_status", capture_state_e'(status[1:0]), cap_held);
        end
        while (state != cap_held) @(posedge clock);
        check_reg("trigger pulse count", pulse_count, 1);
        expect_quiet(50);
        check_reg("words since ack modulo period", out_since_ack % model_period, 0);

        // New frame length and a late external trigger
        reg_write_task(reg_period, 32'd6);
        reg_write_task(reg_trig_pos, 32'd4);
        reg_write_task(reg_trig_sel, 32'd2);
        traffic_on <= 1'b0;
        repeat (4) @(posedge clock);
        ch_since_ack = 0;
        out_since_ack = 0;
        pulse_count = 0;
        reg_write_task(scope_pkg::reg_ack, 32'd1);
        expect_status(cap_armed);
        @(posedge clock);
        ext_trigger <= 1'b1;
        @(posedge clock);
        ext_trigger <= 1'b0;
        repeat (20) @(posedge clock);
        check_reg("pulses before pre-trigger words", pulse_count, 0);
        traffic_on <= 1'b1;
        while (state != cap_held) @(posedge clock);
        check_reg("trigger pulse count", pulse_count, 1);
        expect_quiet(50);
        check_reg("words since ack modulo period", out_since_ack % model_period, 0);

        // Flow resumes after acknowledgement with the second frame length
        reg_write_task(scope_pkg::reg_ack, 32'd1);
        expect_status(cap_armed);
        wait_words(n_test_words / 2);

        reg_write_task(reg_enable, 32'd0);
        expect_status(cap_idle);
        expect_quiet(50);
        traffic_on <= 1'b0;
        check_reg("samples left in combiner", chan_q[0].size() + chan_q[1].size() +
                  chan_q[2].size() + chan_q[3].size() <= 1, 1);

        $display("Errors: data %0d, framing %0d, state %0d, register %0d, other %0d",
                 word_errors, last_errors, state_errors, reg_errors, other_errors);
        if (word_errors + last_errors + state_errors + reg_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
common/scope_pkg.sv
scope/scope_control.sv
scope/channel_combiner.sv
scope/trigger_hub.sv
scope/frame_packer.sv
scope/sample_fifo.sv
verilog/scope_top.sv
bench/scope_tb.sv
